// File: pu_params.svh
////////////////////
// Shared widths, debug memory map and UART bit timing
// Region bases must stay word aligned, RAM size a power of two words
////////////////////

`ifndef PU_PARAMS_SVH
`define PU_PARAMS_SVH

// Bus widths
`define PU_XLEN      32
`define PU_PLEN      32

// RAM region, TOR from base over the full depth
`define PU_RAM_BASE  32'h8000_0000
`define PU_RAM_WORDS 256

// Host interface register, 16 byte NAPOT window
`define PU_TOHOST    32'h8000_1000

// UART transmit word, write only
`define PU_UART_TX   32'h8000_1080

// Clock cycles per serial bit
`define PU_UART_DIV  4

`endif

// File: pu_ahb_pkg.sv
////////////////////
// AHB-Lite encodings for the debug path
// Single transfers only, no bursts or protection
////////////////////

package pu_ahb_pkg;

  // Transfer type, HTRANS
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  // Transfer size, HSIZE
  // Master only issues WORD
  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_t;

endpackage

// File: pu_pma_pkg.sv
////////////////////
// PMA region table encodings plus debug controller states
////////////////////

package pu_pma_pkg;

  // Region that a lookup resolved to
  typedef enum logic [1:0] {
    REG_NONE   = 2'd0,
    REG_RAM    = 2'd1,
    REG_TOHOST = 2'd2,
    REG_UART   = 2'd3
  } pma_region_t;

  // Main memory vs device registers
  typedef enum logic {
    MEM_TYPE_MAIN = 1'b0,
    MEM_TYPE_IO   = 1'b1
  } mem_type_t;

  // Address compare mode, same codes as the pmpcfg A field
  typedef enum logic [1:0] {
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } pma_match_t;

  ////////////////////
  // Debug controller
  ////////////////////

  typedef enum logic [2:0] {
    IDLE, CHECK, ADDR, DATA, UART_WAIT, ACK
  } dbg_state_t;

endpackage

// File: pu_pma_check.sv
////////////////////
// Region lookup for one debug request, result valid the cycle after lookup
// Only word accesses exist, any nonzero addr[1:0] faults
////////////////////

`timescale 1ns/100ps

`include "pu_params.svh"

module pu_pma_check (
  input  logic                    HCLK,
  input  logic                    rst,
  input  logic                    lookup,
  input  logic [`PU_PLEN-1:0]     lookup_addr,
  input  logic                    lookup_we,
  output pu_pma_pkg::pma_region_t region,
  output logic                    allowed
);
  import pu_pma_pkg::*;

  localparam int PMA_CNT = 4;
  // Table holds word addresses, like pmpaddr
  localparam int WA      = `PU_PLEN - 2;

  ////////////////////
  // Region table
  ////////////////////

  // Entry 0 RAM, 1 TOHOST, 2 UART, 3 catch-all with no rights
  // TOR upper bound, NA4 word, or NAPOT encoded base
  localparam logic [WA-1:0] PMA_ADDR [PMA_CNT] = '{
    WA'((`PU_RAM_BASE + 4 * `PU_RAM_WORDS) >> 2),
    WA'((`PU_TOHOST >> 2) | 32'h1),
    WA'(`PU_UART_TX >> 2),
    {WA{1'b1}}
  };
  // TOR lower bound, ignored by the other modes
  localparam logic [WA-1:0] PMA_LO [PMA_CNT] = '{
    WA'(`PU_RAM_BASE >> 2), '0, '0, '0
  };
  localparam pma_match_t  PMA_MATCH  [PMA_CNT] = '{TOR, NAPOT, NA4, NAPOT};
  localparam mem_type_t   PMA_TYPE   [PMA_CNT] = '{MEM_TYPE_MAIN, MEM_TYPE_IO,
                                                   MEM_TYPE_IO, MEM_TYPE_IO};
  localparam pma_region_t PMA_REGION [PMA_CNT] = '{REG_RAM, REG_TOHOST,
                                                   REG_UART, REG_NONE};
  // Bit i belongs to entry i
  localparam logic [PMA_CNT-1:0] PMA_R = 4'b0011;
  localparam logic [PMA_CNT-1:0] PMA_W = 4'b0111;

  logic [1:0] hit_idx;
  logic       aligned;
  logic       perm;

  // Address compare of one entry
  function automatic logic entry_hit(input int idx, input logic [WA-1:0] wa);
    logic [WA-1:0] m;
    // NAPOT size mask, trailing ones plus one bit
    m = PMA_ADDR[idx] ^ (PMA_ADDR[idx] + 1'b1);
    case (PMA_MATCH[idx])
      TOR:     entry_hit = (wa >= PMA_LO[idx]) && (wa < PMA_ADDR[idx]);
      NA4:     entry_hit = (wa == PMA_ADDR[idx]);
      NAPOT:   entry_hit = ((wa & ~m) == (PMA_ADDR[idx] & ~m));
      default: entry_hit = 1'b0;
    endcase
  endfunction

  // Lowest index wins, entry 3 always matches
  always_comb begin
    hit_idx = 2'(PMA_CNT - 1);
    for (int i = PMA_CNT - 1; i >= 0; i--) begin
      if (entry_hit(i, lookup_addr[`PU_PLEN-1:2])) hit_idx = 2'(i);
    end
  end

  assign aligned = (lookup_addr[1:0] == 2'b00);

  // Main memory is always read/write, IO follows its R/W bits
  assign perm = (PMA_TYPE[hit_idx] == MEM_TYPE_MAIN) ||
                (lookup_we ? PMA_W[hit_idx] : PMA_R[hit_idx]);

  always_ff @(posedge HCLK) begin
    if (rst) begin
      region  <= REG_NONE;
      allowed <= 1'b0;
    end else if (lookup) begin
      region  <= PMA_REGION[hit_idx];
      allowed <= aligned && perm;
    end
  end

endmodule

// File: pu_ahb_spram.sv
////////////////////
// AHB-Lite single-port RAM, no HRESP, never stalls writes
// REGISTERED_OUTPUT 1 adds one wait state to every read
////////////////////

`timescale 1ns/100ps

`include "pu_params.svh"

module pu_ahb_spram #(
  parameter int REGISTERED_OUTPUT = 0
) (
  input  logic                HCLK,
  input  logic                rst,
  input  logic                HSEL,
  input  logic [`PU_PLEN-1:0] HADDR,
  input  logic                HWRITE,
  input  pu_ahb_pkg::htrans_t HTRANS,
  input  pu_ahb_pkg::hsize_t  HSIZE,
  input  logic [`PU_XLEN-1:0] HWDATA,
  output logic [`PU_XLEN-1:0] HRDATA,
  output logic                HREADYOUT
);
  import pu_ahb_pkg::*;

  localparam int AW = $clog2(`PU_RAM_WORDS);
  localparam int NB = `PU_XLEN / 8;

  logic [`PU_XLEN-1:0] mem [`PU_RAM_WORDS];

  logic          accept;
  logic [NB-1:0] be;
  logic [AW-1:0] addr_q;
  logic [NB-1:0] be_q;
  logic          wr_q;
  logic          wait_q;

  // Address phase taken only when the slave is ready
  assign accept = HSEL && HREADYOUT &&
                  (HTRANS == HTRANS_NONSEQ || HTRANS == HTRANS_SEQ);

  // Byte lanes from size and low address
  always_comb begin
    case (HSIZE)
      HSIZE_BYTE: be = NB'(1) << HADDR[1:0];
      HSIZE_HALF: be = NB'(3) << {HADDR[1], 1'b0};
      default:    be = '1;
    endcase
  end

  ////////////////////
  // Address phase
  ////////////////////

  always_ff @(posedge HCLK) begin
    if (accept) begin
      addr_q <= HADDR[AW+1:2];
      be_q   <= be;
    end
  end

  always_ff @(posedge HCLK) begin
    if (rst) begin
      wr_q   <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      wr_q   <= accept && HWRITE;
      // One wait cycle per read, only with the output register
      wait_q <= accept && !HWRITE && (REGISTERED_OUTPUT != 0);
    end
  end

  assign HREADYOUT = !wait_q;

  ////////////////////
  // Data phase
  ////////////////////

  always_ff @(posedge HCLK) begin
    if (wr_q) begin
      for (int b = 0; b < NB; b++) begin
        if (be_q[b]) mem[addr_q][b*8 +: 8] <= HWDATA[b*8 +: 8];
      end
    end
  end

  if (REGISTERED_OUTPUT != 0) begin : g_reg_out
    logic [`PU_XLEN-1:0] rdata_q;

    // Loaded in the wait cycle, presented with HREADYOUT
    always_ff @(posedge HCLK) begin
      if (wait_q) rdata_q <= mem[addr_q];
    end
    assign HRDATA = rdata_q;
  end else begin : g_comb_out
    assign HRDATA = mem[addr_q];
  end

endmodule

// File: pu_uart_tx.sv
////////////////////
// 8N1 transmitter, PU_UART_DIV clocks per bit
// tx_start is ignored while busy
////////////////////

`timescale 1ns/100ps

`include "pu_params.svh"

module pu_uart_tx (
  input  logic       HCLK,
  input  logic       rst,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       busy,
  output logic       uart_txd
);

  localparam int DW = $clog2(`PU_UART_DIV + 1);
  // Start bit, eight data bits, stop bit
  localparam int FRAME_BITS = 10;

  logic [FRAME_BITS-1:0] shift_q;
  logic [3:0]            bit_cnt;
  logic [DW-1:0]         div_cnt;
  logic                  bit_end;

  assign bit_end = (div_cnt == DW'(`PU_UART_DIV - 1));

  always_ff @(posedge HCLK) begin
    if (rst) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      div_cnt <= '0;
    end else if (!busy) begin
      if (tx_start) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
        div_cnt <= '0;
      end
    end else if (bit_end) begin
      div_cnt <= '0;
      // Stop bit done, frame over
      if (bit_cnt == 4'(FRAME_BITS - 1)) busy <= 1'b0;
      else bit_cnt <= bit_cnt + 4'd1;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Frame shifted out LSB first
  always_ff @(posedge HCLK) begin
    if (!busy && tx_start) shift_q <= {1'b1, tx_byte, 1'b0};
    else if (busy && bit_end) shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
  end

  // Line idles high between frames
  assign uart_txd = busy ? shift_q[0] : 1'b1;

endmodule

// File: pu_dbg_ctrl.sv
////////////////////
// Debug port sequencer, one request in flight, strobes ignored until dbg_ack
// dbg_dato and dbg_err are valid only in the dbg_ack cycle
////////////////////

`timescale 1ns/100ps

`include "pu_params.svh"

module pu_dbg_ctrl (
  input  logic                    HCLK,
  input  logic                    rst,
  input  logic                    dbg_strb,
  input  logic                    dbg_we,
  input  logic [`PU_PLEN-1:0]     dbg_addr,
  input  logic [`PU_XLEN-1:0]     dbg_dati,
  output logic [`PU_XLEN-1:0]     dbg_dato,
  output logic                    dbg_ack,
  output logic                    dbg_err,
  output logic                    lookup,
  output logic [`PU_PLEN-1:0]     lookup_addr,
  output logic                    lookup_we,
  input  pu_pma_pkg::pma_region_t region,
  input  logic                    allowed,
  output logic                    HSEL,
  output logic [`PU_PLEN-1:0]     HADDR,
  output logic                    HWRITE,
  output pu_ahb_pkg::htrans_t     HTRANS,
  output pu_ahb_pkg::hsize_t      HSIZE,
  output logic [`PU_XLEN-1:0]     HWDATA,
  input  logic [`PU_XLEN-1:0]     HRDATA,
  input  logic                    HREADYOUT,
  output logic                    tx_start,
  output logic [7:0]              tx_byte,
  input  logic                    busy,
  output logic [`PU_XLEN-1:0]     tohost
);
  import pu_ahb_pkg::*;
  import pu_pma_pkg::*;

  dbg_state_t          state_q;
  dbg_state_t          state_d;
  logic [`PU_PLEN-1:0] addr_q;
  logic                we_q;
  logic [`PU_XLEN-1:0] wdata_q;
  logic [`PU_XLEN-1:0] rdata_q;
  logic                err_q;
  logic                go_tohost;

  ////////////////////
  // Request capture
  ////////////////////

  // PMA sees the request in the strobe cycle, result ready in CHECK
  assign lookup      = (state_q == IDLE) && dbg_strb;
  assign lookup_addr = dbg_addr;
  assign lookup_we   = dbg_we;

  always_ff @(posedge HCLK) begin
    if (lookup) begin
      addr_q  <= dbg_addr;
      we_q    <= dbg_we;
      wdata_q <= dbg_dati;
    end
  end

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:  if (dbg_strb) state_d = CHECK;
      CHECK: begin
        if (!allowed) state_d = ACK;
        else begin
          case (region)
            REG_RAM:  state_d = ADDR;
            // Back-pressure from a frame still on the line
            REG_UART: state_d = busy ? UART_WAIT : ACK;
            default:  state_d = ACK;
          endcase
        end
      end
      ADDR:      state_d = DATA;
      DATA:      if (HREADYOUT) state_d = ACK;
      // Region and allowed are held, so CHECK runs again
      UART_WAIT: if (!busy) state_d = CHECK;
      ACK:       state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  assign go_tohost = (state_q == CHECK) && allowed && (region == REG_TOHOST);

  always_ff @(posedge HCLK) begin
    if (rst) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
      rdata_q <= '0;
      tohost  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == CHECK) begin
        err_q   <= !allowed;
        // Zero unless this is a TOHOST read
        rdata_q <= (go_tohost && !we_q) ? tohost : '0;
      end
      if (go_tohost && we_q) tohost <= wdata_q;
      if (state_q == DATA && HREADYOUT) rdata_q <= we_q ? '0 : HRDATA;
    end
  end

  // Debug port response
  assign dbg_ack  = (state_q == ACK);
  assign dbg_err  = dbg_ack && err_q;
  assign dbg_dato = rdata_q;

  ////////////////////
  // AHB master and UART
  ////////////////////

  // Single NONSEQ in ADDR, data phase in DATA
  assign HSEL   = (state_q == ADDR);
  assign HTRANS = (state_q == ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
  assign HADDR  = addr_q;
  assign HWRITE = we_q;
  assign HSIZE  = HSIZE_WORD;
  assign HWDATA = wdata_q;

  // Low byte of the written word goes out on the line
  assign tx_start = (state_q == CHECK) && allowed && (region == REG_UART) && !busy;
  assign tx_byte  = wdata_q[7:0];

endmodule

// File: pu_riscv_synthesis.sv
////////////////////
// Debug bus path of the platform, no core
// RAM read data is combinational, no wait states
////////////////////

`timescale 1ns/100ps

`include "pu_params.svh"

module pu_riscv_synthesis (
  input  logic                HCLK,
  input  logic                rst,
  input  logic                dbg_strb,
  input  logic                dbg_we,
  input  logic [`PU_PLEN-1:0] dbg_addr,
  input  logic [`PU_XLEN-1:0] dbg_dati,
  output logic [`PU_XLEN-1:0] dbg_dato,
  output logic                dbg_ack,
  output logic                dbg_err,
  output logic [`PU_XLEN-1:0] tohost,
  output logic                uart_txd
);
  import pu_ahb_pkg::*;
  import pu_pma_pkg::*;

  // PMA lookup
  logic                lookup;
  logic [`PU_PLEN-1:0] lookup_addr;
  logic                lookup_we;
  pma_region_t         region;
  logic                allowed;

  // AHB-Lite to RAM
  logic                HSEL;
  logic [`PU_PLEN-1:0] HADDR;
  logic                HWRITE;
  htrans_t             HTRANS;
  hsize_t              HSIZE;
  logic [`PU_XLEN-1:0] HWDATA;
  logic [`PU_XLEN-1:0] HRDATA;
  logic                HREADYOUT;

  // UART
  logic                tx_start;
  logic [7:0]          tx_byte;
  logic                busy;

  pu_dbg_ctrl i_pu_dbg_ctrl (
    .HCLK, .rst,
    .dbg_strb, .dbg_we, .dbg_addr, .dbg_dati, .dbg_dato, .dbg_ack, .dbg_err,
    .lookup, .lookup_addr, .lookup_we, .region, .allowed,
    .HSEL, .HADDR, .HWRITE, .HTRANS, .HSIZE, .HWDATA, .HRDATA, .HREADYOUT,
    .tx_start, .tx_byte, .busy,
    .tohost
  );

  pu_pma_check i_pu_pma_check (
    .HCLK, .rst, .lookup, .lookup_addr, .lookup_we, .region, .allowed
  );

  pu_ahb_spram #(
    .REGISTERED_OUTPUT ( 0 )
  ) i_pu_ahb_spram (
    .HCLK, .rst, .HSEL, .HADDR, .HWRITE, .HTRANS, .HSIZE, .HWDATA, .HRDATA, .HREADYOUT
  );

  pu_uart_tx i_pu_uart_tx (
    .HCLK, .rst, .tx_start, .tx_byte, .busy, .uart_txd
  );

endmodule

// File: pu_tb_clk.sv
////////////////////
// Testbench clock, 10 ns period
// rst held high for the first 10 rising edges
////////////////////

`timescale 1ns/100ps

module pu_tb_clk (
  output logic HCLK,
  output logic rst
);

  initial begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  // Released on an edge, like any other synchronous input
  initial begin
    rst = 1'b1;
    repeat (10) @(posedge HCLK);
    rst <= 1'b0;
  end

endmodule

// File: pu_tb.sv
////////////////////
// Debug port testbench for a DUT built with REGISTERED_OUTPUT 0
// Inputs change on the rising edge and outputs are sampled on the falling edge
////////////////////

`timescale 1ns/100ps

`include "pu_params.svh"

module pu_tb;

  typedef struct packed {
    logic                we;
    logic [`PU_PLEN-1:0] addr;
    logic [`PU_XLEN-1:0] data;
    logic                exp_err;
    logic [`PU_XLEN-1:0] exp_dato;
    logic [7:0]          lat;
  } entry_t;

  localparam int TBL_N     = 15;
  localparam int RAND_N    = 16;
  localparam int FRAME_CYC = 10 * `PU_UART_DIV;
  localparam int WD_CYC    = 200 * (TBL_N + 3 * RAND_N) + FRAME_CYC + 20;

  // lat 0 marks a variable latency (UART back-pressure)
  localparam entry_t TBL [TBL_N] = '{
    // we   addr           data           err   dato           lat
    '{1'b1, 32'h8000_0010, 32'h1234_5678, 1'b0, 32'h0000_0000, 8'd4},
    '{1'b0, 32'h8000_0010, 32'h0000_0000, 1'b0, 32'h1234_5678, 8'd4},
    '{1'b1, 32'h8000_03fc, 32'hcafe_f00d, 1'b0, 32'h0000_0000, 8'd4},
    '{1'b0, 32'h8000_03fc, 32'h0000_0000, 1'b0, 32'hcafe_f00d, 8'd4},
    // Faults that must not reach the RAM
    '{1'b1, 32'h8000_0800, 32'hffff_ffff, 1'b1, 32'h0000_0000, 8'd2},
    '{1'b1, 32'h8000_0400, 32'hffff_ffff, 1'b1, 32'h0000_0000, 8'd2},
    '{1'b1, 32'h8000_0012, 32'hdead_beef, 1'b1, 32'h0000_0000, 8'd2},
    '{1'b0, 32'h8000_1080, 32'h0000_0000, 1'b1, 32'h0000_0000, 8'd2},
    '{1'b0, 32'h8000_0010, 32'h0000_0000, 1'b0, 32'h1234_5678, 8'd4},
    // TOHOST window
    '{1'b1, 32'h8000_1000, 32'ha5a5_0001, 1'b0, 32'h0000_0000, 8'd2},
    '{1'b0, 32'h8000_1000, 32'h0000_0000, 1'b0, 32'ha5a5_0001, 8'd2},
    '{1'b1, 32'h8000_100c, 32'h0000_0c0c, 1'b0, 32'h0000_0000, 8'd2},
    '{1'b0, 32'h8000_1004, 32'h0000_0000, 1'b0, 32'h0000_0c0c, 8'd2},
    // Second UART write hits a busy transmitter
    '{1'b1, 32'h8000_1080, 32'h1234_5641, 1'b0, 32'h0000_0000, 8'd2},
    '{1'b1, 32'h8000_1080, 32'h0000_00c3, 1'b0, 32'h0000_0000, 8'd0}
  };

  logic                HCLK;
  logic                rst;
  logic                dbg_strb;
  logic                dbg_we;
  logic [`PU_PLEN-1:0] dbg_addr;
  logic [`PU_XLEN-1:0] dbg_dati;
  logic [`PU_XLEN-1:0] dbg_dato;
  logic                dbg_ack;
  logic                dbg_err;
  logic [`PU_XLEN-1:0] tohost;
  logic                uart_txd;

  int                  val_errs = 0;
  int                  other_errs = 0;
  int                  cyc = 0;
  logic [7:0]          rx_q [$];
  logic [7:0]          exp_q [$];
  logic [`PU_XLEN-1:0] mirror [`PU_RAM_WORDS];

  pu_tb_clk i_pu_tb_clk (.HCLK, .rst);

  pu_riscv_synthesis i_pu_riscv_synthesis (
    .HCLK, .rst, .dbg_strb, .dbg_we, .dbg_addr, .dbg_dati,
    .dbg_dato, .dbg_ack, .dbg_err, .tohost, .uart_txd
  );

  always @(posedge HCLK) cyc <= cyc + 1;

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input logic [`PU_XLEN-1:0] got,
                            input logic [`PU_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      val_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      val_errs++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      val_errs++;
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_quiet_outputs();
    check_bit("dbg_ack", dbg_ack, 1'b0);
    check_bit("dbg_err", dbg_err, 1'b0);
    check_bit("uart_txd", uart_txd, 1'b1);
    check_word("tohost", tohost, '0);
  endtask

  ////////////////////
  // Debug port driver
  ////////////////////

  // Latency counts cycles from the strobe cycle to the ack cycle
  task automatic run_access(input logic we, input logic [`PU_PLEN-1:0] addr,
                            input logic [`PU_XLEN-1:0] data,
                            output logic [`PU_XLEN-1:0] dato, output logic err,
                            output int lat);
    @(posedge HCLK);
    dbg_strb <= 1'b1;
    dbg_we   <= we;
    dbg_addr <= addr;
    dbg_dati <= data;
    @(posedge HCLK);
    dbg_strb <= 1'b0;
    lat = 1;
    @(negedge HCLK);
    while (!dbg_ack) begin
      @(negedge HCLK);
      lat++;
    end
    dato = dbg_dato;
    err  = dbg_err;
  endtask

  task automatic issue_and_check(input logic we, input logic [`PU_PLEN-1:0] addr,
                                 input logic [`PU_XLEN-1:0] data, input logic exp_err,
                                 input logic [`PU_XLEN-1:0] exp_dato, input int exp_lat);
    logic [`PU_XLEN-1:0] dato;
    logic                err;
    int                  lat;
    run_access(we, addr, data, dato, err, lat);
    check_bit("dbg_err", err, exp_err);
    check_word("dbg_dato", dato, exp_dato);
    if (exp_lat != 0 && lat != exp_lat) begin
      $display("Access to 0x%h acked after %0d cycles instead of %0d", addr, lat, exp_lat);
      other_errs++;
    end
  endtask

  ////////////////////
  // UART decoder
  ////////////////////

  // Samples near the middle of each bit
  initial begin : uart_rx
    logic [7:0] b;
    forever begin
      @(negedge uart_txd);
      repeat (`PU_UART_DIV / 2) @(negedge HCLK);
      if (uart_txd !== 1'b0) begin
        $display("UART start bit too short at %0t", $time);
        other_errs++;
      end
      for (int i = 0; i < 8; i++) begin
        repeat (`PU_UART_DIV) @(negedge HCLK);
        b[i] = uart_txd;
      end
      repeat (`PU_UART_DIV) @(negedge HCLK);
      if (uart_txd !== 1'b1) begin
        $display("UART stop bit missing at %0t", $time);
        other_errs++;
      end
      rx_q.push_back(b);
    end
  end

  initial begin : watchdog
    repeat (WD_CYC) @(posedge HCLK);
    $display("Timeout: run did not finish within %0d cycles", WD_CYC);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main
    logic [`PU_XLEN-1:0] exp_tohost;
    logic [31:0]         rnd;
    logic [7:0]          idx;
    logic [`PU_XLEN-1:0] wdata;
    int                  last_uart_ack;
    logic [7:0]          written [$];
    dbg_strb <= 1'b0;
    dbg_we   <= 1'b0;
    dbg_addr <= '0;
    dbg_dati <= '0;
    exp_tohost    = '0;
    rnd           = 32'hcb26_c8a1;
    last_uart_ack = -1;

    // Quiet outputs through reset and a few idle cycles
    @(negedge HCLK);
    while (rst) begin
      check_quiet_outputs();
      @(negedge HCLK);
    end
    repeat (3) begin
      check_quiet_outputs();
      @(negedge HCLK);
    end

    for (int i = 0; i < TBL_N; i++) begin
      issue_and_check(TBL[i].we, TBL[i].addr, TBL[i].data, TBL[i].exp_err,
                      TBL[i].exp_dato, int'(TBL[i].lat));
      if (!TBL[i].exp_err && TBL[i].we && TBL[i].addr[31:4] == `PU_TOHOST >> 4)
        exp_tohost = TBL[i].data;
      check_word("tohost", tohost, exp_tohost);
      if (!TBL[i].exp_err && TBL[i].we && TBL[i].addr == `PU_UART_TX) begin
        exp_q.push_back(TBL[i].data[7:0]);
        // A new frame cannot start before the previous one ends
        if (last_uart_ack >= 0 && cyc - last_uart_ack < FRAME_CYC) begin
          $display("UART write acked %0d cycles after the previous one", cyc - last_uart_ack);
          other_errs++;
        end
        last_uart_ack = cyc;
      end
    end

    // Random RAM write and read-back pairs
    for (int n = 0; n < RAND_N; n++) begin
      rnd   = lcg_next(rnd);
      idx   = rnd[15:8];
      rnd   = lcg_next(rnd);
      wdata = rnd;
      mirror[idx] = wdata;
      written.push_back(idx);
      issue_and_check(1'b1, `PU_RAM_BASE + 32'({idx, 2'b00}), wdata, 1'b0, '0, 4);
      issue_and_check(1'b0, `PU_RAM_BASE + 32'({idx, 2'b00}), '0, 1'b0, mirror[idx], 4);
    end

    // Later random writes must leave every earlier word intact
    for (int k = 0; k < written.size(); k++) begin
      issue_and_check(1'b0, `PU_RAM_BASE + 32'({written[k], 2'b00}), '0, 1'b0,
                      mirror[written[k]], 4);
    end

    while (rx_q.size() < exp_q.size()) @(negedge HCLK);
    if (rx_q.size() != exp_q.size()) begin
      $display("UART sent %0d frames, expected %0d", rx_q.size(), exp_q.size());
      other_errs++;
    end else begin
      for (int i = 0; i < exp_q.size(); i++) check_byte("uart_txd byte", rx_q[i], exp_q[i]);
    end

    $display("Checks done: %0d value errors, %0d other errors", val_errs, other_errs);
    if (val_errs + other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+.
pu_ahb_pkg.sv
pu_pma_pkg.sv
pu_pma_check.sv
pu_ahb_spram.sv
pu_uart_tx.sv
pu_dbg_ctrl.sv
pu_riscv_synthesis.sv
pu_tb_clk.sv
pu_tb.sv

// File: Makefile
# Verilator build of the debug path testbench
# Any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= pu_tb
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_STR  ?= \*\*\* TEST PASSED \*\*\*

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(shell cat $(FLIST) | grep -v '^+') pu_params.svh
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
